// ==== design/icache_pkg.sv ====
// cache geometry, address field widths and controller state type
package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // address and data widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address
  localparam int unsigned ADDR_W   = 32;
  // one instruction word
  localparam int unsigned FETCH_W  = 32;
  // one cache line, four words
  localparam int unsigned LINE_W   = 128;
  // byte offset within a line
  localparam int unsigned OFFSET_W = 4;

  ////////////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_SETS = 16;
  localparam int unsigned INDEX_W  = 4;
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned WAY_W    = 2;

  // whatever is left above index and offset
  localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  ////////////////////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////////////////////

  // FLUSH        clears one set per cycle
  // IDLE         waits for a fetch or a pending flush
  // LOOKUP       array data is back, tag compare
  // REFILL_REQ   mem_req_o held until mem_ack_i
  // REFILL_WAIT  waits for mem_ack_i to fall
  // RESPOND      fetch_ack_o held until fetch_req_i falls
  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND
  } state_e;

endpackage

// ==== design/icache_array_if.sv ====
// array access interface between controller, storage and hit logic
`timescale 1ns/1ns

interface icache_array_if;
  import icache_pkg::*;

  // set index of the incoming or latched fetch, from the top
  logic [INDEX_W-1:0]                 req_index;

  // requests towards the arrays
  logic                               rd_en;
  logic                               wr_en;
  logic                               clr_en;
  logic [INDEX_W-1:0]                 index;
  logic [NUM_WAYS-1:0]                wr_way_oh;
  // write payload, tag of the latched fetch and the refill line
  logic [TAG_W-1:0]                   wr_tag;
  logic [LINE_W-1:0]                  wr_line;

  // read data, one entry per way, valid the cycle after rd_en
  logic [NUM_WAYS-1:0][TAG_W-1:0]     rdata_tag;
  logic [NUM_WAYS-1:0]                rdata_valid;
  logic [NUM_WAYS-1:0][LINE_W-1:0]    rdata_line;

  modport controller (
    input  req_index,
    output rd_en, wr_en, clr_en, index, wr_way_oh
  );

  modport storage (
    input  rd_en, wr_en, clr_en, index, wr_way_oh, wr_tag, wr_line,
    output rdata_tag, rdata_valid, rdata_line
  );

  modport lookup (
    input req_index, rd_en, wr_en, clr_en, index, wr_way_oh, wr_tag, wr_line,
    input rdata_tag, rdata_valid, rdata_line
  );

endinterface

// ==== design/icache_ctrl.sv ====
// controller FSM with flush counter, enable register and handshake control
`timescale 1ns/1ns

module icache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          flush_i,
  input  logic                          fetch_req_i,
  output logic                          fetch_ack_o,
  output logic                          mem_req_o,
  input  logic                          mem_ack_i,
  input  logic                          hit_i,
  input  logic [icache_pkg::NUM_WAYS-1:0] repl_way_oh_i,
  output logic                          fill_o,
  icache_array_if.controller            arr
);
  import icache_pkg::*;

  state_e               state_d, state_q;
  // cache only turns on through a flush
  logic                 en_d, en_q;
  // flush request seen but not yet served
  logic                 flush_d, flush_q;
  logic [INDEX_W-1:0]   flush_cnt_d, flush_cnt_q;
  logic                 ack_d, ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // array requests
  ////////////////////////////////////////////////////////////////////////////

  // refill line is on mem_line_i in the cycle of the ack
  assign fill_o        = (state_q == REFILL_REQ) && mem_ack_i;
  // uncached mode fetches the line but never allocates it
  assign arr.wr_en     = fill_o && en_q;
  assign arr.clr_en    = (state_q == FLUSH);
  assign arr.index     = (state_q == FLUSH) ? flush_cnt_q : arr.req_index;
  assign arr.wr_way_oh = repl_way_oh_i;

  assign mem_req_o     = (state_q == REFILL_REQ);
  assign fetch_ack_o   = ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    // dropping en_i turns the cache off right away
    en_d        = en_q & en_i;
    flush_d     = flush_q | flush_i;
    flush_cnt_d = flush_cnt_q;
    ack_d       = ack_q;
    arr.rd_en   = 1'b0;

    unique case (state_q)
      FLUSH: begin
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_cnt_q == INDEX_W'(NUM_SETS - 1)) begin
          state_d     = IDLE;
          flush_d     = 1'b0;
          flush_cnt_d = '0;
          en_d        = en_i;
        end
      end
      IDLE: begin
        // flush wins over a new fetch, also the flush on enable
        if (flush_d || (en_i && !en_q)) begin
          state_d = FLUSH;
        end else if (fetch_req_i) begin
          // read all ways, address gets latched on the same edge
          arr.rd_en = 1'b1;
          state_d   = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i && en_q) begin
          state_d = RESPOND;
        end else begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        if (mem_ack_i) begin
          state_d = REFILL_WAIT;
        end
      end
      REFILL_WAIT: begin
        // finish the memory handshake before answering
        if (!mem_ack_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (!ack_q) begin
          ack_d = 1'b1;
        end else if (!fetch_req_i) begin
          ack_d   = 1'b0;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      en_q        <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      ack_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      en_q        <= en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      ack_q       <= ack_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, LOOKUP, REFILL_REQ, REFILL_WAIT, RESPOND})
    else $error("icache_ctrl: illegal state %0d", state_q);

  // a refill must never land in a set that is being cleared
  wr_clr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(arr.wr_en && arr.clr_en))
    else $error("icache_ctrl: line write during flush");

endmodule

// ==== design/icache_arrays.sv ====
// tag, valid and line storage for all ways with registered read
`timescale 1ns/1ns

module icache_arrays (
  input  logic             clk_i,
  input  logic             rst_ni,
  icache_array_if.storage  arr
);
  import icache_pkg::*;

  // payload storage, way major
  logic [TAG_W-1:0]                 tag_mem  [NUM_WAYS][NUM_SETS];
  logic [LINE_W-1:0]                line_mem [NUM_WAYS][NUM_SETS];
  // one valid bit per way and set
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (arr.clr_en) begin
          // flush drops the whole set
          valid_q[w][arr.index] <= 1'b0;
        end else if (arr.wr_en && arr.wr_way_oh[w]) begin
          valid_q[w][arr.index] <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tag and line arrays
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr.wr_en && arr.wr_way_oh[w]) begin
        tag_mem[w][arr.index]  <= arr.wr_tag;
        line_mem[w][arr.index] <= arr.wr_line;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////////////////////

  // read data holds until the next rd_en, so the hit word
  // stays valid through RESPOND
  always_ff @(posedge clk_i) begin
    if (arr.rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        arr.rdata_tag[w]  <= tag_mem[w][arr.index];
        arr.rdata_line[w] <= line_mem[w][arr.index];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arr.rdata_valid <= '0;
    end else if (arr.rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        arr.rdata_valid[w] <= valid_q[w][arr.index];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // the replacement choice from the hit logic must name exactly one way
  wr_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr.wr_en |-> $onehot(arr.wr_way_oh))
    else $error("icache_arrays: write way not one-hot %b", arr.wr_way_oh);

endmodule

// ==== design/icache_hit_sel.sv ====
// tag compare, hit word select and replacement way choice with LFSR
`timescale 1ns/1ns

module icache_hit_sel (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [icache_pkg::TAG_W-1:0]      lookup_tag_i,
  input  logic [1:0]                        word_sel_i,
  output logic                              hit_o,
  output logic [icache_pkg::FETCH_W-1:0]    hit_word_o,
  output logic [icache_pkg::NUM_WAYS-1:0]   repl_way_oh_o,
  icache_array_if.lookup                    arr
);
  import icache_pkg::*;

  logic [NUM_WAYS-1:0]  way_hit;
  logic                 all_valid;
  logic [WAY_W-1:0]     inv_way;
  logic [WAY_W-1:0]     repl_way;
  // read data is valid in the cycle after rd_en
  logic                 rd_q;
  logic                 full_q;
  logic [NUM_WAYS-1:0]  repl_way_oh_q;
  logic [15:0]          lfsr_q;
  logic                 lfsr_fb;

  ////////////////////////////////////////////////////////////////////////////
  // hit detection and word mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_word_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = arr.rdata_valid[w] && (arr.rdata_tag[w] == lookup_tag_i);
      // at most one way hits, so an OR is enough
      if (way_hit[w]) begin
        hit_word_o = hit_word_o | arr.rdata_line[w][word_sel_i*FETCH_W +: FETCH_W];
      end
    end
  end

  assign hit_o = |way_hit;

  ////////////////////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////////////////////

  assign all_valid = &arr.rdata_valid;

  // lowest numbered invalid way
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!arr.rdata_valid[w]) begin
        inv_way = WAY_W'(w);
      end
    end
  end

  assign repl_way = all_valid ? lfsr_q[WAY_W-1:0] : inv_way;

  // x^16 + x^14 + x^13 + x^11
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q          <= 1'b0;
      full_q        <= 1'b0;
      repl_way_oh_q <= NUM_WAYS'(1);
      lfsr_q        <= 16'hace1;
    end else begin
      rd_q <= arr.rd_en;
      if (rd_q) begin
        repl_way_oh_q <= NUM_WAYS'(1) << repl_way;
        full_q        <= all_valid;
      end
      // only evictions of a full set consume randomness
      if (arr.wr_en && full_q) begin
        lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      end
    end
  end

  assign repl_way_oh_o = repl_way_oh_q;

  // a second hit means the same line was allocated twice
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_q |-> $onehot0(way_hit))
    else $error("icache_hit_sel: multiple ways hit %b", way_hit);

endmodule

// ==== design/icache_top.sv ====
// cache top level, fetch address latch, refill word capture and wiring
`timescale 1ns/1ns

module icache_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              en_i,
  input  logic                              flush_i,
  input  logic                              fetch_req_i,
  input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
  output logic                              fetch_ack_o,
  output logic [icache_pkg::FETCH_W-1:0]    fetch_data_o,
  output logic                              mem_req_o,
  output logic [icache_pkg::ADDR_W-1:0]     mem_addr_o,
  input  logic                              mem_ack_i,
  input  logic [icache_pkg::LINE_W-1:0]     mem_line_i
);
  import icache_pkg::*;

  icache_array_if arr_if ();

  logic [ADDR_W-1:0]    addr_q;
  logic [TAG_W-1:0]     tag;
  logic [1:0]           word_sel;
  logic                 hit;
  logic [FETCH_W-1:0]   hit_word;
  logic [NUM_WAYS-1:0]  repl_way_oh;
  logic                 fill;
  logic [FETCH_W-1:0]   fill_word_q;
  // answer comes from the refill line, not the arrays
  logic                 use_fill_q;

  // rd_en marks the accepted fetch
  always_ff @(posedge clk_i) begin
    if (arr_if.rd_en) begin
      addr_q <= fetch_addr_i;
    end
    if (fill) begin
      fill_word_q <= mem_line_i[word_sel*FETCH_W +: FETCH_W];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      use_fill_q <= 1'b0;
    end else if (arr_if.rd_en) begin
      use_fill_q <= 1'b0;
    end else if (fill) begin
      use_fill_q <= 1'b1;
    end
  end

  // address fields of the latched fetch
  assign tag      = addr_q[ADDR_W-1 -: TAG_W];
  assign word_sel = addr_q[OFFSET_W-1:2];

  // index comes straight from the port in the accept cycle
  assign arr_if.req_index = arr_if.rd_en ? fetch_addr_i[OFFSET_W +: INDEX_W]
                                         : addr_q[OFFSET_W +: INDEX_W];
  assign arr_if.wr_tag    = tag;
  assign arr_if.wr_line   = mem_line_i;

  // line aligned also in uncached mode
  assign mem_addr_o   = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign fetch_data_o = use_fill_q ? fill_word_q : hit_word;

  icache_ctrl icache_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ack_o   (fetch_ack_o),
    .mem_req_o     (mem_req_o),
    .mem_ack_i     (mem_ack_i),
    .hit_i         (hit),
    .repl_way_oh_i (repl_way_oh),
    .fill_o        (fill),
    .arr           (arr_if.controller)
  );

  icache_arrays icache_arrays_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr_if.storage)
  );

  icache_hit_sel icache_hit_sel_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_tag_i  (tag),
    .word_sel_i    (word_sel),
    .hit_o         (hit),
    .hit_word_o    (hit_word),
    .repl_way_oh_o (repl_way_oh),
    .arr           (arr_if.lookup)
  );

endmodule

// ==== bench/icache_mem_model.sv ====
// refill memory responder with four-phase ack, set delay and address-derived line data
`timescale 1ns/1ns

module icache_mem_model #(
  parameter logic [31:0] PATTERN = 32'h0
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [2:0]    delay_i,
  input  logic          mem_req_i,
  input  logic [31:0]   mem_addr_i,
  output logic          mem_ack_o,
  output logic [127:0]  mem_line_o
);

  // cycles already spent on the open request
  logic [2:0] wait_cnt;

  // word k of the line at base is PATTERN ^ (base + 4k)
  function automatic logic [127:0] line_at(input logic [31:0] base);
    logic [127:0] line;
    for (int k = 0; k < 4; k++) begin
      line[k*32 +: 32] = PATTERN ^ (base + 32'(4 * k));
    end
    return line;
  endfunction

  // outputs change on the falling edge only
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_ack_o  <= 1'b0;
      mem_line_o <= '0;
      wait_cnt   <= '0;
    end else if (mem_ack_o) begin
      // hold the ack until the cache lets go of the request
      if (!mem_req_i) begin
        mem_ack_o <= 1'b0;
      end
    end else if (mem_req_i) begin
      if (wait_cnt >= delay_i) begin
        mem_ack_o  <= 1'b1;
        mem_line_o <= line_at(mem_addr_i);
        wait_cnt   <= '0;
      end else begin
        wait_cnt <= wait_cnt + 3'd1;
      end
    end
  end

endmodule

// ==== bench/icache_tb.sv ====
// testbench top with clock, reset, fetch stimulus, stimulus helpers and handshake checks
`timescale 1ns/1ns

module icache_tb;

  ////////////////////////////////////////////////////////////////////////////
  // constants and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [31:0] SEED        = 32'h85350401;
  localparam logic [31:0] PATTERN     = 32'hc0de_0000;
  // flush, refill and response all fit well inside this
  localparam int          ACK_TIMEOUT = 64;
  localparam int          NUM_TAGS    = 6;
  localparam int          NUM_RANDOM  = 40;

  logic         clk_i;
  logic         rst_ni;
  logic         en_i;
  logic         flush_i;
  logic         fetch_req_i;
  logic [31:0]  fetch_addr_i;
  logic         fetch_ack_o;
  logic [31:0]  fetch_data_o;
  logic         mem_req_o;
  logic [31:0]  mem_addr_o;
  logic         mem_ack_i;
  logic [127:0] mem_line_i;
  logic [2:0]   mem_delay;
  logic [31:0]  rng_state;
  // set once the first fetch is driven
  logic         started;
  int           refill_cnt = 0;

  icache_top icache_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .en_i         (en_i),
    .flush_i      (flush_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ack_o  (fetch_ack_o),
    .fetch_data_o (fetch_data_o),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_ack_i    (mem_ack_i),
    .mem_line_i   (mem_line_i)
  );

  icache_mem_model #(.PATTERN(PATTERN)) icache_mem_model_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .delay_i    (mem_delay),
    .mem_req_i  (mem_req_o),
    .mem_addr_i (mem_addr_o),
    .mem_ack_o  (mem_ack_i),
    .mem_line_o (mem_line_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // one count per refill request
  always @(posedge mem_req_o) begin
    refill_cnt <= refill_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp)
      else abort_run($sformatf("Fail %s: expected %h, actual %h", test, exp, act));
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    assert (act == exp)
      else abort_run($sformatf("Fail %s: expected %0d, actual %0d", test, exp, act));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // six tags on sets 0 and 1 give more lines than ways
  task automatic draw_addr(output logic [31:0] addr);
    logic [31:0] r;
    logic [23:0] tag;
    draw(r);
    tag  = 24'h000400 + 24'(r[7:0] % NUM_TAGS) * 24'h001001;
    addr = {tag, 3'b000, r[8], r[10:9], 2'b00};
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  // full fetch handshake; lat counts cycles from the accept edge to the ack
  task automatic run_fetch(input string name, input logic [31:0] addr,
                           output int lat, output int refills);
    logic [31:0] r;
    int          waited;
    int          first_refill;
    first_refill = refill_cnt;
    draw(r);
    mem_delay    = r[2:0];
    fetch_addr_i = addr;
    fetch_req_i  = 1'b1;
    started      = 1'b1;
    waited       = 0;
    while (!fetch_ack_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > ACK_TIMEOUT) begin
        abort_run($sformatf("%s: no fetch ack within %0d cycles", name, ACK_TIMEOUT));
      end
    end
    lat     = waited - 1;
    refills = refill_cnt - first_refill;
    // word aligned address gives PATTERN ^ addr as the expected word
    check_value(name, PATTERN ^ addr, fetch_data_o);
    // request stays up past the ack for one to four cycles
    repeat (r[4:3] + 1) @(negedge clk_i);
    fetch_req_i = 1'b0;
    waited      = 0;
    while (fetch_ack_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > ACK_TIMEOUT) begin
        abort_run($sformatf("%s: fetch ack stuck high after request dropped", name));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // handshake properties
  ////////////////////////////////////////////////////////////////////////////

  quiet_before_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started |-> !fetch_ack_o && !mem_req_o)
    else abort_run("fetch ack or refill request raised before any fetch");

  mem_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> mem_addr_o[3:0] == 4'h0)
    else abort_run("refill address is not line aligned");

  mem_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && $past(mem_req_o) |-> mem_addr_o == $past(mem_addr_o))
    else abort_run("refill address changed while the request was open");

  ack_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(fetch_ack_o && fetch_req_i) |-> fetch_ack_o)
    else abort_run("fetch ack dropped while the request was still high");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] addr;
    int          lat;
    int          refills;

    rng_state    = SEED;
    rst_ni       = 1'b0;
    en_i         = 1'b0;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    mem_delay    = '0;
    started      = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    // handshakes must stay quiet over a few idle cycles
    repeat (4) @(negedge clk_i);

    // cache is disabled after reset and every fetch goes to memory
    draw_addr(addr);
    run_fetch("uncached_first", addr, lat, refills);
    check_count("uncached_first refills", 1, refills);
    run_fetch("uncached_again", addr, lat, refills);
    check_count("uncached_again refills", 1, refills);

    // enable flushes first, then allocates
    en_i = 1'b1;
    run_fetch("enable_miss", addr, lat, refills);
    check_count("enable_miss refills", 1, refills);
    run_fetch("enable_hit", addr ^ 32'h4, lat, refills);
    check_count("enable_hit refills", 0, refills);
    check_count("enable_hit latency", 2, lat);

    // random lines over two sets include evictions
    for (int i = 0; i < NUM_RANDOM; i++) begin
      draw_addr(addr);
      run_fetch("random_fetch", addr, lat, refills);
      run_fetch("repeat_hit", addr ^ 32'h8, lat, refills);
      check_count("repeat_hit refills", 0, refills);
      check_count("repeat_hit latency", 2, lat);
    end

    // flush drops the line just used
    pulse_flush();
    run_fetch("flush_miss", addr, lat, refills);
    check_count("flush_miss refills", 1, refills);
    run_fetch("flush_hit", addr, lat, refills);
    check_count("flush_hit refills", 0, refills);
    check_count("flush_hit latency", 2, lat);

    // uncached again even though the line is still valid
    en_i = 1'b0;
    run_fetch("disabled_first", addr, lat, refills);
    check_count("disabled_first refills", 1, refills);
    run_fetch("disabled_again", addr, lat, refills);
    check_count("disabled_again refills", 1, refills);
    en_i = 1'b1;
    run_fetch("reenable_miss", addr, lat, refills);
    check_count("reenable_miss refills", 1, refills);
    run_fetch("reenable_hit", addr, lat, refills);
    check_count("reenable_hit refills", 0, refills);
    check_count("reenable_hit latency", 2, lat);

    repeat (4) @(negedge clk_i);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
design/icache_pkg.sv
design/icache_array_if.sv
design/icache_ctrl.sv
design/icache_arrays.sv
design/icache_hit_sel.sv
design/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// ==== Makefile ====
TOOL       := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := icache_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
